// File: include/sec_cache_settings.svh
`ifndef SEC_CACHE_SETTINGS_SVH
`define SEC_CACHE_SETTINGS_SVH

// Word widths
`define SC_ADDR_W 32
`define SC_DATA_W 32

// Direct-mapped geometry with one word per line
`define SC_INDEX_W 3
`define SC_LINES 8
`define SC_OFFSET_W 2
`define SC_TAG_W (`SC_ADDR_W - `SC_INDEX_W - `SC_OFFSET_W)

// ------------------------------
// Special addresses
// ------------------------------

// Always uncached
`define SC_DIRECT_ADDR 32'h0000_0000
// Boundary register that only the high domain may write
`define SC_CTRL_ADDR 32'h0000_0004
`define SC_RESET_BOUNDARY 32'h0000_c000

`endif

// File: hdl/sec_cache_pkg.sv
`default_nettype none

`include "sec_cache_settings.svh"

package sec_cache_pkg;

	// Request kind on both the processor and memory side
	typedef enum logic {
		req_read  = 1'b0,
		req_write = 1'b1
	} req_type_e;

	// How an accepted request is serviced
	typedef enum logic [1:0] {
		path_direct = 2'd0,
		path_ctrl   = 2'd1,
		path_refuse = 2'd2,
		path_cached = 2'd3
	} path_e;

	// ------------------------------
	// Address word
	// ------------------------------

	// Boundary check reads the whole word, cache lookup reads the fields
	typedef union packed {
		logic [`SC_ADDR_W-1:0] flat;
		struct packed {
			logic [`SC_TAG_W-1:0]    tag;
			logic [`SC_INDEX_W-1:0]  index;
			logic [`SC_OFFSET_W-1:0] offset;
		} fields;
	} cache_addr_u;

endpackage

`default_nettype wire

// File: hdl/req_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "sec_cache_settings.svh"

module req_decode (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       req_val,
	output logic                       req_rdy,
	input  sec_cache_pkg::req_type_e   req_type,
	input  logic                       req_domain,
	input  logic [`SC_ADDR_W-1:0]      req_addr,
	input  logic [`SC_DATA_W-1:0]      req_data,
	input  logic [`SC_ADDR_W-1:0]      boundary,
	input  logic                       busy,
	input  logic                       dec_take,
	output logic                       dec_val,
	output sec_cache_pkg::path_e       dec_path,
	output sec_cache_pkg::req_type_e   dec_type,
	output logic                       dec_domain,
	output sec_cache_pkg::cache_addr_u dec_addr,
	output logic [`SC_DATA_W-1:0]      dec_data
);
	import sec_cache_pkg::*;

	// Set from acceptance until the response reaches the result stage
	logic  pend;
	logic  accept;
	path_e req_path;

	assign req_rdy = !pend && !busy;
	assign accept = req_val && req_rdy;

	// ------------------------------
	// Path classification
	// ------------------------------

	always_comb begin
		if (req_addr == `SC_DIRECT_ADDR) begin
			req_path = path_direct;
		end else if (req_addr == `SC_CTRL_ADDR) begin
			// Only the high domain may move the boundary
			req_path = req_domain ? path_ctrl : path_refuse;
		end else if (req_addr >= boundary) begin
			req_path = path_cached;
		end else begin
			req_path = path_direct;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pend <= 1'b0;
			dec_val <= 1'b0;
		end else if (accept) begin
			pend <= 1'b1;
			dec_val <= 1'b1;
		end else begin
			if (dec_take)
				dec_val <= 1'b0;
			if (busy)
				pend <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			dec_path <= req_path;
			dec_type <= req_type;
			dec_domain <= req_domain;
			dec_addr.flat <= req_addr;
			dec_data <= req_data;
		end
	end

endmodule

`default_nettype wire

// File: hdl/cache_execute.sv
`timescale 1ns/1ns
`default_nettype none

`include "sec_cache_settings.svh"

module cache_execute (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       dec_val,
	input  sec_cache_pkg::path_e       dec_path,
	input  sec_cache_pkg::req_type_e   dec_type,
	input  logic                       dec_domain,
	input  sec_cache_pkg::cache_addr_u dec_addr,
	input  logic [`SC_DATA_W-1:0]      dec_data,
	output logic                       dec_take,
	output logic [`SC_ADDR_W-1:0]      boundary,
	output logic                       ex_done,
	output logic [`SC_DATA_W-1:0]      ex_data,
	output logic                       ex_domain,
	output logic                       mem_req_val,
	output sec_cache_pkg::req_type_e   mem_req_type,
	output logic                       mem_req_domain,
	output logic [`SC_ADDR_W-1:0]      mem_req_addr,
	output logic [`SC_DATA_W-1:0]      mem_req_data,
	input  logic                       mem_req_rdy,
	input  logic                       mem_resp_val,
	input  logic [`SC_DATA_W-1:0]      mem_resp_data
);
	import sec_cache_pkg::*;

	localparam logic [2:0] st_idle     = 3'd0;
	localparam logic [2:0] st_lookup   = 3'd1;
	localparam logic [2:0] st_mem_req  = 3'd2;
	localparam logic [2:0] st_mem_wait = 3'd3;
	localparam logic [2:0] st_done     = 3'd4;

	logic [2:0] state;
	logic [2:0] next_state;

	// Request being serviced
	path_e                 cur_path;
	req_type_e             cur_type;
	logic                  cur_domain;
	cache_addr_u           cur_addr;
	logic [`SC_DATA_W-1:0] cur_data;
	logic [`SC_DATA_W-1:0] mem_data_q;

	// Line arrays
	logic [`SC_LINES-1:0]  line_valid;
	logic [`SC_LINES-1:0]  line_domain;
	logic [`SC_TAG_W-1:0]  line_tag [`SC_LINES];
	logic [`SC_DATA_W-1:0] line_data [`SC_LINES];

	logic [`SC_INDEX_W-1:0] idx;
	logic                   hit;
	logic                   fast_path;
	logic                   write_hit;
	logic                   fill;
	logic                   ctrl_write;

	assign idx = cur_addr.fields.index;

	// Tag and filling domain must both match
	assign hit = line_valid[idx] && (line_tag[idx] == cur_addr.fields.tag)
		&& (line_domain[idx] == cur_domain);

	// Finished in the lookup cycle without touching memory
	assign fast_path = (cur_path == path_ctrl) || (cur_path == path_refuse)
		|| (cur_path == path_cached && cur_type == req_read && hit);

	assign ctrl_write = (state == st_lookup) && (cur_path == path_ctrl);
	assign write_hit = (state == st_lookup) && (cur_path == path_cached)
		&& (cur_type == req_write) && hit;
	assign fill = (state == st_mem_wait) && mem_resp_val
		&& (cur_path == path_cached) && (cur_type == req_read);

	// ------------------------------
	// Controller
	// ------------------------------

	always_ff @(posedge clk) begin
		if (reset)
			state <= st_idle;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			st_idle: begin
				if (dec_val)
					next_state = st_lookup;
			end
			st_lookup: begin
				if (fast_path)
					next_state = st_idle;
				else
					next_state = st_mem_req;
			end
			st_mem_req: begin
				if (mem_req_rdy)
					next_state = st_mem_wait;
			end
			// Memory answers at least one cycle after the request transfers
			st_mem_wait: begin
				if (mem_resp_val)
					next_state = st_done;
			end
			st_done: next_state = st_idle;
			default: next_state = st_idle;
		endcase
	end

	assign dec_take = (state == st_idle) && dec_val;

	always_ff @(posedge clk) begin
		if (dec_take) begin
			cur_path <= dec_path;
			cur_type <= dec_type;
			cur_domain <= dec_domain;
			cur_addr <= dec_addr;
			cur_data <= dec_data;
		end
		if (state == st_mem_wait && mem_resp_val)
			mem_data_q <= mem_resp_data;
	end

	// ------------------------------
	// Boundary and cache state
	// ------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			boundary <= `SC_RESET_BOUNDARY;
			line_valid <= '0;
		end else if (ctrl_write) begin
			// New boundary flushes every line
			boundary <= cur_data;
			line_valid <= '0;
		end else if (fill) begin
			line_valid[idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fill) begin
			line_domain[idx] <= cur_domain;
			line_tag[idx] <= cur_addr.fields.tag;
			line_data[idx] <= mem_resp_data;
		end else if (write_hit) begin
			line_data[idx] <= cur_data;
		end
	end

	// ------------------------------
	// Outputs
	// ------------------------------

	assign ex_done = ((state == st_lookup) && fast_path) || (state == st_done);
	assign ex_domain = cur_domain;

	// Writes, control and refused requests answer zero
	always_comb begin
		ex_data = '0;
		if (cur_type == req_read) begin
			if (state == st_done)
				ex_data = mem_data_q;
			else if (cur_path == path_cached)
				ex_data = line_data[idx];
		end
	end

	assign mem_req_val = (state == st_mem_req);
	assign mem_req_type = cur_type;
	assign mem_req_domain = cur_domain;
	assign mem_req_addr = cur_addr.flat;
	assign mem_req_data = cur_data;

endmodule

`default_nettype wire

// File: hdl/resp_result.sv
`timescale 1ns/1ns
`default_nettype none

`include "sec_cache_settings.svh"

module resp_result (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  ex_done,
	input  logic [`SC_DATA_W-1:0] ex_data,
	input  logic                  ex_domain,
	input  logic                  resp_rdy,
	output logic                  resp_val,
	output logic                  resp_domain,
	output logic [`SC_DATA_W-1:0] resp_data,
	output logic                  busy
);

	// ------------------------------
	// Response hold
	// ------------------------------

	always_ff @(posedge clk) begin
		if (reset)
			resp_val <= 1'b0;
		else if (ex_done)
			resp_val <= 1'b1;
		else if (resp_rdy)
			resp_val <= 1'b0;
	end

	// Captured once and held stable through back-pressure
	always_ff @(posedge clk) begin
		if (ex_done) begin
			resp_domain <= ex_domain;
			resp_data <= ex_data;
		end
	end

	// Blocks new requests from ex_done until the response leaves
	assign busy = ex_done || resp_val;

endmodule

`default_nettype wire

// File: hdl/sec_cache_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "sec_cache_settings.svh"

module sec_cache_top (
	input  logic                     clk,
	input  logic                     reset,
	// Processor request
	input  logic                     req_val,
	output logic                     req_rdy,
	input  sec_cache_pkg::req_type_e req_type,
	input  logic                     req_domain,
	input  logic [`SC_ADDR_W-1:0]    req_addr,
	input  logic [`SC_DATA_W-1:0]    req_data,
	// Processor response
	output logic                     resp_val,
	input  logic                     resp_rdy,
	output logic                     resp_domain,
	output logic [`SC_DATA_W-1:0]    resp_data,
	// Memory side
	output logic                     mem_req_val,
	input  logic                     mem_req_rdy,
	output sec_cache_pkg::req_type_e mem_req_type,
	output logic                     mem_req_domain,
	output logic [`SC_ADDR_W-1:0]    mem_req_addr,
	output logic [`SC_DATA_W-1:0]    mem_req_data,
	input  logic                     mem_resp_val,
	input  logic [`SC_DATA_W-1:0]    mem_resp_data
);
	import sec_cache_pkg::*;

	logic                  dec_val;
	path_e                 dec_path;
	req_type_e             dec_type;
	logic                  dec_domain;
	cache_addr_u           dec_addr;
	logic [`SC_DATA_W-1:0] dec_data;
	logic                  dec_take;
	logic [`SC_ADDR_W-1:0] boundary;
	logic                  ex_done;
	logic [`SC_DATA_W-1:0] ex_data;
	logic                  ex_domain;
	logic                  busy;

	req_decode u_decode (
		.clk(clk), .reset(reset),
		.req_val(req_val), .req_rdy(req_rdy), .req_type(req_type),
		.req_domain(req_domain), .req_addr(req_addr), .req_data(req_data),
		.boundary(boundary), .busy(busy), .dec_take(dec_take),
		.dec_val(dec_val), .dec_path(dec_path), .dec_type(dec_type),
		.dec_domain(dec_domain), .dec_addr(dec_addr), .dec_data(dec_data)
	);

	cache_execute u_execute (
		.clk(clk), .reset(reset),
		.dec_val(dec_val), .dec_path(dec_path), .dec_type(dec_type),
		.dec_domain(dec_domain), .dec_addr(dec_addr), .dec_data(dec_data),
		.dec_take(dec_take), .boundary(boundary),
		.ex_done(ex_done), .ex_data(ex_data), .ex_domain(ex_domain),
		.mem_req_val(mem_req_val), .mem_req_type(mem_req_type),
		.mem_req_domain(mem_req_domain), .mem_req_addr(mem_req_addr),
		.mem_req_data(mem_req_data), .mem_req_rdy(mem_req_rdy),
		.mem_resp_val(mem_resp_val), .mem_resp_data(mem_resp_data)
	);

	resp_result u_result (
		.clk(clk), .reset(reset),
		.ex_done(ex_done), .ex_data(ex_data), .ex_domain(ex_domain),
		.resp_rdy(resp_rdy), .resp_val(resp_val),
		.resp_domain(resp_domain), .resp_data(resp_data), .busy(busy)
	);

endmodule

`default_nettype wire

// File: verif/sec_cache_props.sv
`timescale 1ns/1ns
`default_nettype none

`include "sec_cache_settings.svh"

module sec_cache_props (
	input logic                     clk,
	input logic                     reset,
	input logic                     req_rdy,
	input logic                     resp_val,
	input logic                     resp_rdy,
	input logic                     resp_domain,
	input logic [`SC_DATA_W-1:0]    resp_data,
	input logic                     mem_req_val,
	input logic                     mem_req_rdy,
	input sec_cache_pkg::req_type_e mem_req_type,
	input logic                     mem_req_domain,
	input logic [`SC_ADDR_W-1:0]    mem_req_addr,
	input logic [`SC_DATA_W-1:0]    mem_req_data
);

	int prop_errors = 0;

	// ------------------------------
	// Handshake rules
	// ------------------------------

	resp_hold: assert property (@(posedge clk) disable iff (reset)
		resp_val && !resp_rdy |=> resp_val && $stable(resp_data) && $stable(resp_domain))
	else begin
		$error("Response dropped or changed before resp_rdy");
		prop_errors++;
	end

	mem_req_hold: assert property (@(posedge clk) disable iff (reset)
		mem_req_val && !mem_req_rdy |=> mem_req_val && $stable(mem_req_type)
			&& $stable(mem_req_domain) && $stable(mem_req_addr) && $stable(mem_req_data))
	else begin
		$error("Memory request dropped or changed before mem_req_rdy");
		prop_errors++;
	end

	// No new request while a response waits
	busy_blocks_req: assert property (@(posedge clk) disable iff (reset)
		resp_val |-> !req_rdy)
	else begin
		$error("req_rdy high while resp_val is held");
		prop_errors++;
	end

endmodule

`default_nettype wire

// File: verif/sec_cache_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "sec_cache_settings.svh"

module sec_cache_tb;
	import sec_cache_pkg::*;

	localparam int num_random = 150;
	// About 200 requests at a worst case of 40 cycles each
	localparam int cycle_limit = 200 * 40;

	logic                  clk = 1'b0;
	logic                  reset;
	logic                  req_val;
	logic                  req_rdy;
	req_type_e             req_type;
	logic                  req_domain;
	logic [`SC_ADDR_W-1:0] req_addr;
	logic [`SC_DATA_W-1:0] req_data;
	logic                  resp_val;
	logic                  resp_rdy;
	logic                  resp_domain;
	logic [`SC_DATA_W-1:0] resp_data;
	logic                  mem_req_val;
	logic                  mem_req_rdy;
	req_type_e             mem_req_type;
	logic                  mem_req_domain;
	logic [`SC_ADDR_W-1:0] mem_req_addr;
	logic [`SC_DATA_W-1:0] mem_req_data;
	logic                  mem_resp_val;
	logic [`SC_DATA_W-1:0] mem_resp_data;

	integer seed = 32'h2425923b;
	logic   stall = 1'b0;
	int     errors = 0;
	int     cycles = 0;

	// Memory model state and the last request it saw
	logic [`SC_DATA_W-1:0] mem_words [logic [`SC_ADDR_W-1:0]];
	int                    mem_count = 0;
	logic [`SC_ADDR_W-1:0] last_addr;
	logic [`SC_DATA_W-1:0] last_data;
	logic                  last_wr;
	logic                  last_dom;

	// Reference cache
	logic [`SC_ADDR_W-1:0] ref_boundary;
	logic                  ref_valid [`SC_LINES];
	logic                  ref_dom [`SC_LINES];
	logic [`SC_TAG_W-1:0]  ref_tag [`SC_LINES];
	logic [`SC_DATA_W-1:0] ref_data [`SC_LINES];

	sec_cache_top dut (.*);

	bind sec_cache_top sec_cache_props handshake_props (
		.clk(clk), .reset(reset), .req_rdy(req_rdy),
		.resp_val(resp_val), .resp_rdy(resp_rdy),
		.resp_domain(resp_domain), .resp_data(resp_data),
		.mem_req_val(mem_req_val), .mem_req_rdy(mem_req_rdy),
		.mem_req_type(mem_req_type), .mem_req_domain(mem_req_domain),
		.mem_req_addr(mem_req_addr), .mem_req_data(mem_req_data)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display(">>> FAIL");
			$finish;
		end
	end

	function automatic logic [`SC_DATA_W-1:0] fill_word(input logic [`SC_ADDR_W-1:0] addr);
		return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
	endfunction

	function automatic logic [`SC_DATA_W-1:0] mem_read(input logic [`SC_ADDR_W-1:0] addr);
		if (mem_words.exists(addr))
			return mem_words[addr];
		return fill_word(addr);
	endfunction

	function automatic logic pick_ready();
		if (!stall)
			return 1'b1;
		return ($unsigned($random(seed)) % 3) == 0;
	endfunction

	// Ready inputs go low for random stretches while stalling
	always @(posedge clk) begin
		#1;
		mem_req_rdy = pick_ready();
		resp_rdy = pick_ready();
	end

	// ------------------------------
	// Memory model
	// ------------------------------

	initial begin : memory_model
		int                    delay;
		logic [`SC_DATA_W-1:0] rdata;
		mem_resp_val = 1'b0;
		mem_resp_data = '0;
		forever begin
			@(negedge clk);
			if (mem_req_val && mem_req_rdy) begin
				mem_count++;
				last_addr = mem_req_addr;
				last_data = mem_req_data;
				last_wr = (mem_req_type == req_write);
				last_dom = mem_req_domain;
				rdata = '0;
				if (last_wr)
					mem_words[mem_req_addr] = mem_req_data;
				else
					rdata = mem_read(mem_req_addr);
				delay = stall ? ($unsigned($random(seed)) % 4) : 0;
				@(posedge clk);
				#1;
				repeat (delay) begin
					@(posedge clk);
					#1;
				end
				mem_resp_val = 1'b1;
				mem_resp_data = rdata;
				@(posedge clk);
				#1;
				mem_resp_val = 1'b0;
			end
		end
	end

	// Expected response and memory traffic by the path rules
	task automatic predict(input logic wr, input logic dom, input logic [`SC_ADDR_W-1:0] addr,
			input logic [`SC_DATA_W-1:0] wdata, output logic [`SC_DATA_W-1:0] exp_data,
			output logic exp_mem);
		logic [`SC_INDEX_W-1:0] idx;
		logic [`SC_TAG_W-1:0]   tag;
		logic                   hit;
		idx = addr[`SC_OFFSET_W +: `SC_INDEX_W];
		tag = addr[`SC_ADDR_W-1 -: `SC_TAG_W];
		hit = ref_valid[idx] && (ref_tag[idx] == tag) && (ref_dom[idx] == dom);
		exp_data = '0;
		exp_mem = 1'b1;
		if (addr == `SC_CTRL_ADDR) begin
			exp_mem = 1'b0;
			if (dom) begin
				ref_boundary = wdata;
				for (int i = 0; i < `SC_LINES; i++)
					ref_valid[i] = 1'b0;
			end
		end else if (addr != `SC_DIRECT_ADDR && addr >= ref_boundary) begin
			if (!wr && hit) begin
				exp_data = ref_data[idx];
				exp_mem = 1'b0;
			end else if (!wr) begin
				exp_data = mem_read(addr);
				ref_valid[idx] = 1'b1;
				ref_dom[idx] = dom;
				ref_tag[idx] = tag;
				ref_data[idx] = exp_data;
			end else if (hit) begin
				ref_data[idx] = wdata;
			end
		end else if (!wr) begin
			exp_data = mem_read(addr);
		end
	endtask

	task automatic do_access(input logic wr, input logic dom, input logic [`SC_ADDR_W-1:0] addr,
			input logic [`SC_DATA_W-1:0] wdata);
		logic [`SC_DATA_W-1:0] exp_data;
		logic                  exp_mem;
		int                    mem_before;
		logic [`SC_DATA_W-1:0] got_data;
		logic                  got_dom;
		predict(wr, dom, addr, wdata, exp_data, exp_mem);
		mem_before = mem_count;
		@(posedge clk);
		#1;
		req_val = 1'b1;
		req_type = wr ? req_write : req_read;
		req_domain = dom;
		req_addr = addr;
		req_data = wdata;
		@(negedge clk);
		while (!req_rdy)
			@(negedge clk);
		@(posedge clk);
		#1;
		req_val = 1'b0;
		@(negedge clk);
		while (!(resp_val && resp_rdy))
			@(negedge clk);
		got_data = resp_data;
		got_dom = resp_domain;
		assert (got_data == exp_data) else begin
			$display("Fail %0t: addr %h domain %0d returned %h, expected %h",
				$time, addr, dom, got_data, exp_data);
			errors++;
		end
		assert (got_dom == dom) else begin
			$display("Fail %0t: addr %h response domain %0d, expected %0d",
				$time, addr, got_dom, dom);
			errors++;
		end
		assert (mem_count - mem_before == int'(exp_mem)) else begin
			$display("Fail %0t: addr %h domain %0d made %0d memory requests, expected %0d",
				$time, addr, dom, mem_count - mem_before, exp_mem);
			errors++;
		end
		if (exp_mem && mem_count != mem_before) begin
			assert (last_addr == addr && last_wr == wr && last_dom == dom
					&& (!wr || last_data == wdata)) else begin
				$display("Fail %0t: memory request for addr %h carried addr %h data %h",
					$time, addr, last_addr, last_data);
				errors++;
			end
		end
	endtask

	// ------------------------------
	// Stimulus
	// ------------------------------

	initial begin : stimulus
		logic [31:0]           r;
		logic [`SC_ADDR_W-1:0] addr;
		logic [`SC_DATA_W-1:0] wdata;
		logic                  wr;
		req_val = 1'b0;
		req_type = req_read;
		req_domain = 1'b0;
		req_addr = '0;
		req_data = '0;
		resp_rdy = 1'b0;
		mem_req_rdy = 1'b0;
		reset = 1'b1;
		ref_boundary = `SC_RESET_BOUNDARY;
		for (int i = 0; i < `SC_LINES; i++)
			ref_valid[i] = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		@(negedge clk);
		assert (!resp_val && !mem_req_val) else begin
			$display("Fail %0t: resp_val or mem_req_val high after reset", $time);
			errors++;
		end

		// Miss, hit, write-through, then the other domain
		do_access(1'b0, 1'b0, 32'h0000_c040, '0);
		do_access(1'b0, 1'b0, 32'h0000_c040, '0);
		do_access(1'b1, 1'b0, 32'h0000_c040, 32'h1234_5678);
		do_access(1'b0, 1'b0, 32'h0000_c040, '0);
		repeat (2) do_access(1'b0, 1'b1, 32'h0000_c040, '0);

		// Uncached addresses
		repeat (2) do_access(1'b0, 1'b0, `SC_DIRECT_ADDR, '0);
		do_access(1'b1, 1'b1, `SC_DIRECT_ADDR, 32'haaaa_5555);
		repeat (2) do_access(1'b0, 1'b1, 32'h0000_0100, '0);
		do_access(1'b1, 1'b0, 32'h0000_0200, 32'h0bad_cafe);

		// Boundary register
		do_access(1'b1, 1'b0, `SC_CTRL_ADDR, 32'h0000_0080);
		repeat (2) do_access(1'b0, 1'b0, 32'h0000_0100, '0);
		do_access(1'b1, 1'b1, `SC_CTRL_ADDR, 32'h0000_0080);
		repeat (2) do_access(1'b0, 1'b0, 32'h0000_0100, '0);
		repeat (2) do_access(1'b0, 1'b1, 32'h0000_c040, '0);
		repeat (2) do_access(1'b0, 1'b0, 32'h0000_0040, '0);

		// Random mix under back-pressure
		stall = 1'b1;
		for (int i = 0; i < num_random; i++) begin
			r = $random(seed);
			wdata = $random(seed);
			wr = r[4];
			case (r[2:0])
				3'd0: addr = `SC_DIRECT_ADDR;
				3'd1: addr = `SC_CTRL_ADDR;
				3'd2: addr = 32'h0000_0040;
				3'd3: addr = 32'h0000_0100 + {r[6:5], 2'b00};
				3'd4: addr = 32'h0000_1040;
				default: addr = 32'h0000_c000 + {r[8:5], 2'b00};
			endcase
			if (addr == `SC_CTRL_ADDR) begin
				wr = 1'b1;
				wdata = (r[10:9] == 2'd0) ? 32'h0000_0080
					: (r[10:9] == 2'd1) ? 32'h0000_1000 : `SC_RESET_BOUNDARY;
			end
			do_access(wr, r[3], addr, wdata);
		end
		stall = 1'b0;

		repeat (2) @(posedge clk);
		$display("Errors: %0d in testbench checks, %0d in handshake assertions",
			errors, dut.handshake_props.prop_errors);
		if (errors == 0 && dut.handshake_props.prop_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+include
hdl/sec_cache_pkg.sv
hdl/req_decode.sv
hdl/cache_execute.sv
hdl/resp_result.sv
hdl/sec_cache_top.sv
verif/sec_cache_props.sv
verif/sec_cache_tb.sv
